// ==== rtl/fetch_macros.svh ====
// --------------------
// fetch stage sizing
// widths and depths shared by the fetch RTL
// --------------------

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// --------------------
// datapath
// --------------------

// address and instruction word width
`define FETCH_ADDR_W 32

// --------------------
// buffering
// --------------------

// fetched words held in the prefetch queue
`define FETCH_QUEUE_DEPTH 4

// granted but unanswered bus requests
`define FETCH_MAX_OUTSTANDING 2

`endif

// ==== rtl/fetch_pkg.sv ====
// --------------------
// fetch package
// mux selects for next-PC and trap vectoring,
// plus the queued instruction record
// --------------------

`include "fetch_macros.svh"

package fetch_pkg;

  // next-PC source, driven by the controller
  typedef enum logic [3:0] {
    PC_BOOT      = 4'b0000,
    PC_FENCEI    = 4'b0001,
    PC_JUMP      = 4'b0010,  // target resolved in ID
    PC_BRANCH    = 4'b0011,  // target resolved in EX
    PC_EXCEPTION = 4'b0100,
    PC_MRET      = 4'b0101,
    PC_DRET      = 4'b0111
  } pc_mux_e;

  // exception target select
  typedef enum logic [2:0] {
    EXC_PC_EXCEPTION = 3'b000,
    EXC_PC_IRQ       = 3'b001,  // vectored
    EXC_PC_DBD       = 3'b010,  // debug halt
    EXC_PC_DBE       = 3'b011   // debug exception
  } exc_pc_mux_e;

  // trap base select
  typedef enum logic [1:0] {
    TRAP_MACHINE = 2'b00,
    TRAP_USER    = 2'b01
  } trap_mux_e;

  // one queued instruction with the address it came from
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] addr;
    logic [`FETCH_ADDR_W-1:0] data;
  } fetch_word_t;

endpackage

// ==== rtl/fetch_fifo.sv ====
// --------------------
// fetch fifo
// small circular queue, payload type set per instance
// flush drops all entries in one cycle
// --------------------

module fetch_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned DEPTH     = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         flush_i,   // wins over push and pop
  input  logic                         push_i,
  input  payload_t                     data_i,
  input  logic                         pop_i,
  output payload_t                     data_o,    // head entry, valid when not empty
  output logic                         empty_o,
  output logic                         full_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t          mem_q [DEPTH];
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              do_push;
  logic              do_pop;

  // wrap at DEPTH, so non power of two depths work too
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign count_o = cnt_q;
  assign data_o  = mem_q[rd_ptr_q];

  assign do_pop  = pop_i & ~empty_o;
  assign do_push = push_i & (~full_o | do_pop);  // full + pop frees a slot this cycle

  // --------------------
  // pointers and fill level
  // --------------------

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      unique case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== rtl/pc_select.sv ====
// --------------------
// pc select
// picks the redirect target for the fetch unit:
// boot, jumps, trap vectors, returns, debug and fence.i
// also flags the boot redirect so the CSR file can init mtvec
// --------------------

`include "fetch_macros.svh"

module pc_select (
  input  fetch_pkg::pc_mux_e          pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e      exc_pc_mux_i,
  input  fetch_pkg::trap_mux_e        trap_addr_mux_i,

  input  logic [23:0]                 m_trap_base_addr_i,  // mtvec[31:8]
  input  logic [23:0]                 u_trap_base_addr_i,
  input  logic [4:0]                  m_exc_vec_i,         // irq id
  input  logic [4:0]                  u_exc_vec_i,

  input  logic [`FETCH_ADDR_W-1:0]    boot_addr_i,
  input  logic [`FETCH_ADDR_W-1:0]    dm_halt_addr_i,
  input  logic [`FETCH_ADDR_W-1:0]    dm_exception_addr_i,
  input  logic [`FETCH_ADDR_W-1:0]    jump_target_id_i,
  input  logic [`FETCH_ADDR_W-1:0]    jump_target_ex_i,
  input  logic [`FETCH_ADDR_W-1:0]    mepc_i,
  input  logic [`FETCH_ADDR_W-1:0]    depc_i,
  input  logic [`FETCH_ADDR_W-1:0]    pc_id_i,             // instr currently in ID

  input  logic                        pc_set_i,

  output logic [`FETCH_ADDR_W-1:0]    branch_addr_o,
  output logic                        csr_mtvec_init_o
);

  logic [23:0]               trap_base;
  logic [4:0]                exc_vec;
  logic [`FETCH_ADDR_W-1:0]  exc_pc;
  logic [`FETCH_ADDR_W-1:0]  next_pc;

  // --------------------
  // trap vectoring
  // --------------------

  always_comb begin
    // base and vector come from the same privilege level
    unique case (trap_addr_mux_i)
      fetch_pkg::TRAP_USER: begin
        trap_base = u_trap_base_addr_i;
        exc_vec   = u_exc_vec_i;
      end
      default: begin
        trap_base = m_trap_base_addr_i;
        exc_vec   = m_exc_vec_i;
      end
    endcase

    unique case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_IRQ: exc_pc = {trap_base, 1'b0, exc_vec, 2'b00};  // base + 4*id
      fetch_pkg::EXC_PC_DBD: exc_pc = {dm_halt_addr_i[31:2], 2'b00};
      fetch_pkg::EXC_PC_DBE: exc_pc = {dm_exception_addr_i[31:2], 2'b00};
      default:               exc_pc = {trap_base, 8'h00};  // all sync exceptions share base
    endcase
  end

  // --------------------
  // next pc
  // --------------------

  always_comb begin
    unique case (pc_mux_i)
      fetch_pkg::PC_JUMP:      next_pc = jump_target_id_i;
      fetch_pkg::PC_BRANCH:    next_pc = jump_target_ex_i;
      fetch_pkg::PC_EXCEPTION: next_pc = exc_pc;
      fetch_pkg::PC_MRET:      next_pc = mepc_i;   // back from handler
      fetch_pkg::PC_DRET:      next_pc = depc_i;   // leave debug mode
      fetch_pkg::PC_FENCEI:    next_pc = pc_id_i + 32'd4;  // refetch after fence.i
      default:                 next_pc = boot_addr_i;
    endcase
  end

  // only 32-bit instructions, so targets are always word aligned
  assign branch_addr_o = {next_pc[31:2], 2'b00};

  // mtvec takes its reset value on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == fetch_pkg::PC_BOOT);

endmodule

// ==== rtl/prefetch_buffer.sv ====
// --------------------
// prefetch buffer
// issues sequential word fetches on the instruction bus,
// tracks addresses in flight and queues the returned words
// responses older than a redirect are dropped
// --------------------

`include "fetch_macros.svh"

module prefetch_buffer (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        req_i,          // fetch enable
  input  logic                        branch_i,       // redirect pulse
  input  logic [`FETCH_ADDR_W-1:0]    branch_addr_i,

  input  logic                        fetch_pop_i,    // head consumed by IF/ID
  output logic                        fetch_valid_o,
  output fetch_pkg::fetch_word_t      fetch_word_o,

  // instruction memory bus
  output logic                        instr_req_o,
  output logic [`FETCH_ADDR_W-1:0]    instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  logic [`FETCH_ADDR_W-1:0]    instr_rdata_i,

  output logic                        busy_o
);

  localparam int unsigned MAX_OUT  = `FETCH_MAX_OUTSTANDING;
  localparam int unsigned Q_DEPTH  = `FETCH_QUEUE_DEPTH;
  localparam int unsigned AQ_CNT_W = $clog2(MAX_OUT + 1);
  localparam int unsigned WQ_CNT_W = $clog2(Q_DEPTH + 1);
  localparam int unsigned SUM_W    = WQ_CNT_W + 1;  // room for in flight + queued

  logic                          active_q;      // set by first redirect after reset
  logic                          req_hold_q;    // request up, not yet granted
  logic [`FETCH_ADDR_W-1:0]      fetch_addr_q;
  logic [AQ_CNT_W-1:0]           stale_q;       // in flight but belong to an old path
  logic [AQ_CNT_W-1:0]           stale_d;
  logic [AQ_CNT_W-1:0]           addr_cnt;
  logic [WQ_CNT_W-1:0]           word_cnt;
  logic [SUM_W-1:0]              in_flight;
  logic                          space_ok;
  logic                          gnt_fire;
  logic                          resp_live;
  logic                          word_empty;
  logic [`FETCH_ADDR_W-1:0]      resp_addr;
  fetch_pkg::fetch_word_t        resp_word;

  // --------------------
  // request side
  // --------------------

  assign in_flight = SUM_W'(addr_cnt) + SUM_W'(stale_q);

  // every in-flight word must already have a queue slot waiting for it
  assign space_ok = (in_flight < SUM_W'(MAX_OUT)) &&
                    ((in_flight + SUM_W'(word_cnt)) < SUM_W'(Q_DEPTH));

  // once raised the request holds until granted, a redirect withdraws it
  assign instr_req_o  = active_q & ~branch_i & (req_hold_q | (req_i & space_ok));
  assign instr_addr_o = fetch_addr_q;
  assign gnt_fire     = instr_req_o & instr_gnt_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      req_hold_q   <= 1'b0;
      fetch_addr_q <= '0;
      stale_q      <= '0;
    end else begin
      stale_q <= stale_d;
      if (branch_i) begin
        active_q     <= 1'b1;
        req_hold_q   <= 1'b0;
        fetch_addr_q <= branch_addr_i;  // new path starts next cycle
      end else begin
        req_hold_q <= instr_req_o & ~instr_gnt_i;
        if (gnt_fire) fetch_addr_q <= fetch_addr_q + 32'd4;
      end
    end
  end

  // --------------------
  // response side
  // --------------------

  // a redirect turns everything still in flight into stale
  always_comb begin
    stale_d = stale_q;
    if (branch_i) begin
      stale_d = AQ_CNT_W'(in_flight - SUM_W'(instr_rvalid_i));
    end else if (instr_rvalid_i && (stale_q != '0)) begin
      stale_d = stale_q - 1'b1;  // drop one old response
    end
  end

  assign resp_live = instr_rvalid_i & (stale_q == '0) & ~branch_i;
  assign resp_word = '{addr: resp_addr, data: instr_rdata_i};

  // addresses of live requests, in grant order
  fetch_fifo #(
    .payload_t (logic [`FETCH_ADDR_W-1:0]),
    .DEPTH     (MAX_OUT)
  ) addr_fifo0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (branch_i),
    .push_i  (gnt_fire),
    .data_i  (fetch_addr_q),
    .pop_i   (instr_rvalid_i & (stale_q == '0)),
    .data_o  (resp_addr),
    .empty_o (),
    .full_o  (),
    .count_o (addr_cnt)
  );

  // fetched words waiting for decode
  fetch_fifo #(
    .payload_t (fetch_pkg::fetch_word_t),
    .DEPTH     (Q_DEPTH)
  ) word_fifo0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (branch_i),
    .push_i  (resp_live),
    .data_i  (resp_word),
    .pop_i   (fetch_pop_i),
    .data_o  (fetch_word_o),
    .empty_o (word_empty),
    .full_o  (),
    .count_o (word_cnt)
  );

  assign fetch_valid_o = ~word_empty;
  assign busy_o        = (in_flight != '0);

endmodule

// ==== rtl/if_id_reg.sv ====
// --------------------
// IF/ID register
// holds one instruction and its pc for decode
// inserts a bubble when decode is ready but nothing is queued
// --------------------

`include "fetch_macros.svh"

module if_id_reg (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        fetch_valid_i,  // queue not empty
  input  fetch_pkg::fetch_word_t      fetch_word_i,
  output logic                        fetch_pop_o,

  input  logic                        id_ready_i,
  input  logic                        halt_if_i,
  input  logic                        clear_i,        // kill the instr in ID
  input  logic                        pc_set_i,       // redirect, same effect

  output logic                        instr_valid_id_o,
  output logic [`FETCH_ADDR_W-1:0]    instr_rdata_id_o,
  output logic [`FETCH_ADDR_W-1:0]    pc_id_o
);

  logic advance;
  logic kill;

  assign advance = id_ready_i & ~halt_if_i;
  assign kill    = clear_i | pc_set_i;

  // take the head only when it really lands in the register
  assign fetch_pop_o = advance & fetch_valid_i & ~kill;

  // valid bit
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
    end else if (kill) begin
      instr_valid_id_o <= 1'b0;
    end else if (advance) begin
      instr_valid_id_o <= fetch_valid_i;  // bubble when queue is empty
    end
  end

  // instruction and pc, follow the pop
  always_ff @(posedge clk) begin
    if (fetch_pop_o) begin
      instr_rdata_id_o <= fetch_word_i.data;
      pc_id_o          <= fetch_word_i.addr;
    end
  end

endmodule

// ==== rtl/fetch_stage.sv ====
// --------------------
// fetch stage top
// pc select -> prefetch buffer -> IF/ID register
// --------------------

`include "fetch_macros.svh"

module fetch_stage (
  input  logic                        clk,
  input  logic                        rst_n,

  // redirect control
  input  fetch_pkg::pc_mux_e          pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e      exc_pc_mux_i,
  input  fetch_pkg::trap_mux_e        trap_addr_mux_i,
  input  logic [23:0]                 m_trap_base_addr_i,
  input  logic [23:0]                 u_trap_base_addr_i,
  input  logic [4:0]                  m_exc_vec_i,
  input  logic [4:0]                  u_exc_vec_i,
  input  logic [`FETCH_ADDR_W-1:0]    boot_addr_i,
  input  logic [`FETCH_ADDR_W-1:0]    dm_halt_addr_i,
  input  logic [`FETCH_ADDR_W-1:0]    dm_exception_addr_i,
  input  logic [`FETCH_ADDR_W-1:0]    jump_target_id_i,
  input  logic [`FETCH_ADDR_W-1:0]    jump_target_ex_i,
  input  logic [`FETCH_ADDR_W-1:0]    mepc_i,
  input  logic [`FETCH_ADDR_W-1:0]    depc_i,
  input  logic                        req_i,
  input  logic                        pc_set_i,

  // instruction memory bus
  output logic                        instr_req_o,
  output logic [`FETCH_ADDR_W-1:0]    instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  logic [`FETCH_ADDR_W-1:0]    instr_rdata_i,

  // pipeline
  input  logic                        id_ready_i,
  input  logic                        halt_if_i,
  input  logic                        clear_instr_valid_i,
  output logic                        instr_valid_id_o,
  output logic [`FETCH_ADDR_W-1:0]    instr_rdata_id_o,
  output logic [`FETCH_ADDR_W-1:0]    pc_id_o,

  output logic                        csr_mtvec_init_o,
  output logic                        if_busy_o,
  output logic                        perf_imiss_o  // starved, not redirecting
);

  logic [`FETCH_ADDR_W-1:0]  branch_addr;
  logic                      fetch_valid;
  fetch_pkg::fetch_word_t    fetch_word;
  logic                      fetch_pop;

  pc_select pc_select0 (
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .trap_addr_mux_i     (trap_addr_mux_i),
    .m_trap_base_addr_i  (m_trap_base_addr_i),
    .u_trap_base_addr_i  (u_trap_base_addr_i),
    .m_exc_vec_i         (m_exc_vec_i),
    .u_exc_vec_i         (u_exc_vec_i),
    .boot_addr_i         (boot_addr_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .jump_target_id_i    (jump_target_id_i),
    .jump_target_ex_i    (jump_target_ex_i),
    .mepc_i              (mepc_i),
    .depc_i              (depc_i),
    .pc_id_i             (pc_id_o),      // fence.i restarts after ID instr
    .pc_set_i            (pc_set_i),
    .branch_addr_o       (branch_addr),
    .csr_mtvec_init_o    (csr_mtvec_init_o)
  );

  prefetch_buffer prefetch_buffer0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .fetch_pop_i    (fetch_pop),
    .fetch_valid_o  (fetch_valid),
    .fetch_word_o   (fetch_word),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (if_busy_o)
  );

  if_id_reg if_id_reg0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_valid_i    (fetch_valid),
    .fetch_word_i     (fetch_word),
    .fetch_pop_o      (fetch_pop),
    .id_ready_i       (id_ready_i),
    .halt_if_i        (halt_if_i),
    .clear_i          (clear_instr_valid_i),
    .pc_set_i         (pc_set_i),
    .instr_valid_id_o (instr_valid_id_o),
    .instr_rdata_id_o (instr_rdata_id_o),
    .pc_id_o          (pc_id_o)
  );

  assign perf_imiss_o = ~fetch_valid & ~pc_set_i;

endmodule

// ==== verification/fetch_assertions.sv ====
// --------------------
// fetch stage bus and pipeline checks
// bound into the fetch top level
// --------------------

module fetch_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic        pc_set_i,
  input logic        req_i,     // instr_req_o of the DUT
  input logic [31:0] addr_i,
  input logic        gnt_i,
  input logic        clear_i,
  input logic        valid_i    // instr_valid_id_o
);

  int fail_cnt = 0;  // read by the testbench

  // a request holds with the same address until granted, only a redirect withdraws it
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
      req_i && !gnt_i |=> pc_set_i || (req_i && $stable(addr_i)))
    else begin
      $error("fetch request dropped or address changed before grant");
      fail_cnt = fail_cnt + 1;
    end

  addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      req_i |-> addr_i[1:0] == 2'b00)
    else begin
      $error("fetch request address not word aligned");
      fail_cnt = fail_cnt + 1;
    end

  // the instr in ID is killed one cycle after the clear
  clear_kills: assert property (@(posedge clk) disable iff (!rst_n)
      clear_i |=> !valid_i)
    else begin
      $error("instr still valid in ID after clear");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind fetch_stage fetch_assertions sva0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .pc_set_i (pc_set_i),
  .req_i    (instr_req_o),
  .addr_i   (instr_addr_o),
  .gnt_i    (instr_gnt_i),
  .clear_i  (clear_instr_valid_i),
  .valid_i  (instr_valid_id_o)
);

// ==== verification/fetch_tb.sv ====
// --------------------
// fetch stage testbench
// memory with random grant and response delays, random redirects and stalls,
// delivered instructions checked against a PC model
// --------------------

module fetch_tb;

  localparam int          N_SEQ      = 16;    // in-order deliveries after boot
  localparam int          N_RAND     = 2000;  // random control cycles
  localparam int          MAX_CYCLES = 200 * (N_SEQ + 8) + N_RAND + 500;
  localparam logic [31:0] BOOT_ADDR  = 32'h0000_1080;

  logic clk;
  logic rst_n;
  fetch_pkg::pc_mux_e     pc_mux_i;
  fetch_pkg::exc_pc_mux_e exc_pc_mux_i;
  fetch_pkg::trap_mux_e   trap_addr_mux_i;
  logic [23:0] m_trap_base_addr_i, u_trap_base_addr_i;
  logic [4:0]  m_exc_vec_i, u_exc_vec_i;
  logic [31:0] boot_addr_i, dm_halt_addr_i, dm_exception_addr_i;
  logic [31:0] jump_target_id_i, jump_target_ex_i, mepc_i, depc_i;
  logic        req_i, pc_set_i, id_ready_i, halt_if_i, clear_instr_valid_i;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic        instr_valid_id_o, csr_mtvec_init_o, if_busy_o, perf_imiss_o;
  logic [31:0] instr_rdata_id_o, pc_id_o;

  integer      seed = 32'ha93ef13e;
  int          cyc = 0;
  logic [31:0] rsp_addr_q[$];       // granted, not yet answered
  int          rsp_due_q[$];        // cycle of the answer
  int          rsp_epoch_q[$];      // redirect epoch at grant time
  int          gnt_wait, last_due;
  logic [31:0] exp_pc, last_pc;     // model next pc and last delivered pc
  logic        have_pc, model_valid, prev_adv, prev_kill;
  logic        prev_load;           // queue head taken into IF/ID last cycle
  logic        boot_pulse;          // boot redirect driven this cycle
  int          q_words;             // words the prefetch queue should hold
  int          epoch, resp_epoch;   // bumped on every redirect
  int          delivered, target_cnt;
  int          src_hits[7];

  fetch_stage dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit
  initial begin
    while (cyc <= MAX_CYCLES) begin
      @(posedge clk);
      cyc = cyc + 1;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Errors found");
    $fatal(1, "timeout");
  end

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  // memory content mixing every address bit
  function automatic logic [31:0] scramble(input logic [31:0] addr);
    return ({addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1) * 32'h9e37_79b1 + addr;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "mismatch");
    end
  endtask

  // --------------------
  // reference pc model
  // --------------------

  function automatic logic [31:0] redirect_target();
    logic [23:0] base;
    logic [4:0]  vec;
    logic [31:0] tgt;
    base = (trap_addr_mux_i == fetch_pkg::TRAP_USER) ? u_trap_base_addr_i : m_trap_base_addr_i;
    vec  = (trap_addr_mux_i == fetch_pkg::TRAP_USER) ? u_exc_vec_i : m_exc_vec_i;
    case (pc_mux_i)
      fetch_pkg::PC_JUMP:   tgt = jump_target_id_i;
      fetch_pkg::PC_BRANCH: tgt = jump_target_ex_i;
      fetch_pkg::PC_MRET:   tgt = mepc_i;
      fetch_pkg::PC_DRET:   tgt = depc_i;
      fetch_pkg::PC_FENCEI: tgt = last_pc + 32'd4;   // after the instr in ID
      fetch_pkg::PC_EXCEPTION: begin
        case (exc_pc_mux_i)
          fetch_pkg::EXC_PC_IRQ: tgt = (32'(base) << 8) + 32'(vec) * 4;
          fetch_pkg::EXC_PC_DBD: tgt = dm_halt_addr_i;
          fetch_pkg::EXC_PC_DBE: tgt = dm_exception_addr_i;
          default:               tgt = 32'(base) << 8;
        endcase
      end
      default: tgt = boot_addr_i;
    endcase
    return tgt & 32'hffff_fffc;
  endfunction

  // pulse pc_set with fresh operands; sel 0 boot .. 6 fence.i
  task automatic drive_redirect(input int sel);
    if (sel == 6 && !have_pc) sel = 1;  // no pc in ID yet
    boot_pulse          = (sel == 0);
    pc_set_i            = 1'b1;
    m_trap_base_addr_i  = $random(seed);
    u_trap_base_addr_i  = $random(seed);
    m_exc_vec_i         = $random(seed);
    u_exc_vec_i         = $random(seed);
    dm_halt_addr_i      = $random(seed);       // low bits dropped by the DUT
    dm_exception_addr_i = $random(seed);
    jump_target_id_i    = $random(seed) & 32'hffff_fffc;
    jump_target_ex_i    = $random(seed) & 32'hffff_fffc;
    mepc_i              = $random(seed) & 32'hffff_fffc;
    depc_i              = $random(seed) & 32'hffff_fffc;
    exc_pc_mux_i        = fetch_pkg::exc_pc_mux_e'(rand_below(4));
    trap_addr_mux_i     = fetch_pkg::trap_mux_e'(rand_below(2));
    case (sel)
      0:       pc_mux_i = fetch_pkg::PC_BOOT;
      1:       pc_mux_i = fetch_pkg::PC_JUMP;
      2:       pc_mux_i = fetch_pkg::PC_BRANCH;
      3:       pc_mux_i = fetch_pkg::PC_EXCEPTION;
      4:       pc_mux_i = fetch_pkg::PC_MRET;
      5:       pc_mux_i = fetch_pkg::PC_DRET;
      default: pc_mux_i = fetch_pkg::PC_FENCEI;
    endcase
    exp_pc = redirect_target();
    src_hits[sel] = src_hits[sel] + 1;
  endtask

  // --------------------
  // one clock cycle of checks, stimulus and bus sampling
  // --------------------

  task automatic step(input bit random_ctl, input bit boot);
    int due;
    @(posedge clk);
    #1;
    if (prev_kill) begin
      check_value("valid after clear or redirect", instr_valid_id_o, 1'b0);
      model_valid = 1'b0;
    end else if (!prev_adv) begin
      check_value("valid held in stall", instr_valid_id_o, model_valid);
      if (model_valid) check_value("pc held in stall", pc_id_o, last_pc);
    end else begin
      check_value("valid after advance", instr_valid_id_o, prev_load);  // word or bubble
      model_valid = prev_load;
      if (prev_load) begin
        check_value("delivered pc", pc_id_o, exp_pc);
        check_value("delivered data", instr_rdata_id_o, scramble(exp_pc));
        last_pc   = exp_pc;
        have_pc   = 1'b1;
        exp_pc    = exp_pc + 32'd4;
        delivered = delivered + 1;
      end
    end
    check_value("assertion failures", dut0.sva0.fail_cnt, 0);

    pc_set_i            = 1'b0;
    clear_instr_valid_i = 1'b0;
    boot_pulse          = 1'b0;
    if (boot) begin
      drive_redirect(0);
    end else if (random_ctl) begin
      id_ready_i          = rand_below(4) != 0;
      halt_if_i           = rand_below(10) == 0;
      req_i               = rand_below(16) != 0;
      clear_instr_valid_i = rand_below(25) == 0;
      if (rand_below(20) == 0) drive_redirect(rand_below(7));
    end else begin
      id_ready_i = 1'b1;
      halt_if_i  = 1'b0;
      req_i      = 1'b1;
    end
    prev_adv  = id_ready_i & ~halt_if_i;
    prev_kill = clear_instr_valid_i | pc_set_i;

    // memory grants after a random wait and answers in order
    instr_gnt_i = (gnt_wait == 0);
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = scramble(rsp_addr_q.pop_front());
      resp_epoch     = rsp_epoch_q.pop_front();
      void'(rsp_due_q.pop_front());
    end else begin
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = $random(seed);
    end

    @(negedge clk);
    check_value("mtvec init", csr_mtvec_init_o, boot_pulse);
    check_value("busy", if_busy_o, rsp_addr_q.size() != 0 || instr_rvalid_i);
    check_value("imiss", perf_imiss_o, q_words == 0 && !pc_set_i);
    if (instr_req_o && instr_gnt_i) begin
      due = cyc + 1 + rand_below(3);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rsp_addr_q.push_back(instr_addr_o);
      rsp_due_q.push_back(due);
      rsp_epoch_q.push_back(epoch);
      gnt_wait = rand_below(3);
    end else if (instr_req_o) begin
      gnt_wait = gnt_wait - 1;
    end

    // queue contents after the next edge
    prev_load = prev_adv && !prev_kill && q_words != 0;
    if (pc_set_i) begin
      q_words = 0;          // flushed
      epoch   = epoch + 1;  // answers to older grants are dropped
    end else begin
      if (instr_rvalid_i && resp_epoch == epoch) q_words = q_words + 1;
      if (prev_load) q_words = q_words - 1;
    end
  endtask

  initial begin
    rst_n = 1'b0;
    pc_mux_i = fetch_pkg::PC_BOOT;
    exc_pc_mux_i = fetch_pkg::EXC_PC_EXCEPTION;
    trap_addr_mux_i = fetch_pkg::TRAP_MACHINE;
    {m_trap_base_addr_i, u_trap_base_addr_i, m_exc_vec_i, u_exc_vec_i} = '0;
    {dm_halt_addr_i, dm_exception_addr_i, jump_target_id_i, jump_target_ex_i} = '0;
    {mepc_i, depc_i} = '0;
    boot_addr_i = BOOT_ADDR;
    {req_i, pc_set_i, id_ready_i, halt_if_i, clear_instr_valid_i} = '0;
    {instr_gnt_i, instr_rvalid_i, instr_rdata_i} = '0;
    {gnt_wait, last_due, delivered} = '0;
    {q_words, epoch, resp_epoch} = '0;
    {exp_pc, last_pc, have_pc, model_valid, prev_adv, prev_kill} = '0;
    {prev_load, boot_pulse} = '0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // boot, then straight-line fetch
    repeat (3) step(0, 0);
    step(0, 1);
    while (delivered < N_SEQ) step(0, 0);
    check_value("pc after boot run", pc_id_o, BOOT_ADDR + 4 * (N_SEQ - 1));

    // latency, back-pressure, redirects, stalls
    repeat (N_RAND) step(1, 0);
    target_cnt = delivered + 8;
    while (delivered < target_cnt) step(0, 0);
    for (int i = 0; i < 7; i++) begin
      check_value("redirect source exercised", src_hits[i] != 0, 1'b1);
    end

    if (dut0.sva0.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
      $fatal(1, "assertion failure");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_fifo.sv
rtl/pc_select.sv
rtl/prefetch_buffer.sv
rtl/if_id_reg.sv
rtl/fetch_stage.sv
verification/fetch_assertions.sv
verification/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_fifo.sv
      - rtl/pc_select.sv
      - rtl/prefetch_buffer.sv
      - rtl/if_id_reg.sv
      - rtl/fetch_stage.sv
  - target: test
    files:
      - verification/fetch_assertions.sv
      - verification/fetch_tb.sv
